/* src/vga_pkg.sv */
package vga_pkg;

	typedef logic [9:0] coord_t;
	// Byte order is blue, green, red from the top
	typedef logic [23:0] rgb_t;
	// One bit per lives marker
	typedef logic [4:0] lives_t;

	// Horizontal timing in pixels
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_BACK = 48;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// Vertical timing in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 33;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// Player boxes and lives markers
	localparam int SPRITE_SIZE = 32;
	localparam int MARKER_SIZE = 10;
	localparam int MARKER_PITCH = 15;
	localparam int MARKER_Y = 10;
	localparam int LIVES1_X = 150;
	localparam int LIVES2_X = 455;

	localparam rgb_t COLOR_BG = 24'h202020;
	// Orange and pink, written as {b, g, r}
	localparam rgb_t COLOR_P1 = 24'h0080FF;
	localparam rgb_t COLOR_P2 = 24'hB469FF;
	localparam rgb_t COLOR_LIVES1 = 24'h00007C;
	localparam rgb_t COLOR_LIVES2 = 24'hAAAAAA;
	// Yellow end screen when player 1 is out
	localparam rgb_t COLOR_END1 = 24'h00FFFF;
	// Blue end screen when player 2 is out
	localparam rgb_t COLOR_END2 = 24'hFF0000;

endpackage

/* src/pixel_if.sv */
`timescale 1ns/1ps

interface pixel_if;
	vga_pkg::coord_t x;
	vga_pkg::coord_t y;
	logic active;
	// Both syncs are active low
	logic hs;
	logic vs;

	modport src (
		output x, y, active, hs, vs
	);

	modport snk (
		input x, y, active, hs, vs
	);

endinterface

/* src/vga_sync_gen.sv */
`timescale 1ns/1ps

module vga_sync_gen (
	input logic VGA_CLK_n,
	input logic iRST_n,
	pixel_if.src pix
);

	vga_pkg::coord_t h_cnt;
	vga_pkg::coord_t v_cnt;
	vga_pkg::coord_t h_next;
	vga_pkg::coord_t v_next;
	logic hs_next;
	logic vs_next;
	logic active_next;
	logic hs_q;
	logic vs_q;
	logic active_q;

	// Next position in the frame
	always_comb begin
		if (h_cnt == vga_pkg::coord_t'(vga_pkg::H_TOTAL - 1)) begin
			h_next = '0;
			if (v_cnt == vga_pkg::coord_t'(vga_pkg::V_TOTAL - 1))
				v_next = '0;
			else
				v_next = v_cnt + 1'b1;
		end else begin
			h_next = h_cnt + 1'b1;
			v_next = v_cnt;
		end
	end

	// Sync and active flags follow the next position so all outputs line up
	assign hs_next = !((h_next >= vga_pkg::H_ACTIVE + vga_pkg::H_FRONT) &&
		(h_next < vga_pkg::H_ACTIVE + vga_pkg::H_FRONT + vga_pkg::H_SYNC));
	assign vs_next = !((v_next >= vga_pkg::V_ACTIVE + vga_pkg::V_FRONT) &&
		(v_next < vga_pkg::V_ACTIVE + vga_pkg::V_FRONT + vga_pkg::V_SYNC));
	assign active_next = (h_next < vga_pkg::H_ACTIVE) && (v_next < vga_pkg::V_ACTIVE);

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			h_cnt <= '0;
			v_cnt <= '0;
			hs_q <= 1'b1;
			vs_q <= 1'b1;
			active_q <= 1'b0;
		end else begin
			h_cnt <= h_next;
			v_cnt <= v_next;
			hs_q <= hs_next;
			vs_q <= vs_next;
			active_q <= active_next;
		end
	end

	assign pix.x = h_cnt;
	assign pix.y = v_cnt;
	assign pix.hs = hs_q;
	assign pix.vs = vs_q;
	assign pix.active = active_q;

endmodule

/* src/sprite_hit_stage.sv */
`timescale 1ns/1ps

module sprite_hit_stage (
	input logic VGA_CLK_n,
	input logic iRST_n,
	pixel_if.snk pix_in,
	pixel_if.src pix_out,
	input vga_pkg::coord_t p1_x,
	input vga_pkg::coord_t p1_y,
	input vga_pkg::coord_t p2_x,
	input vga_pkg::coord_t p2_y,
	input vga_pkg::lives_t p1_lives,
	input vga_pkg::lives_t p2_lives,
	output logic p1_hit,
	output logic p2_hit,
	output logic [1:0] marker_hit
);

	localparam int N_MARKERS = $bits(vga_pkg::lives_t);

	vga_pkg::lives_t lives [2];
	vga_pkg::lives_t mark_cover [2];
	logic [1:0] marker_next;
	logic p1_next;
	logic p2_next;

	// Half-open span [lo, lo+size)
	function automatic logic in_span(input vga_pkg::coord_t pos, input vga_pkg::coord_t lo,
		input int size);
		return (pos >= lo) && (int'(pos) < int'(lo) + size);
	endfunction

	assign lives[0] = p1_lives;
	assign lives[1] = p2_lives;

	assign p1_next = in_span(pix_in.x, p1_x, vga_pkg::SPRITE_SIZE) &&
		in_span(pix_in.y, p1_y, vga_pkg::SPRITE_SIZE);
	assign p2_next = in_span(pix_in.x, p2_x, vga_pkg::SPRITE_SIZE) &&
		in_span(pix_in.y, p2_y, vga_pkg::SPRITE_SIZE);

	for (genvar k = 0; k < 2; k++) begin : g_player
		localparam int BASE_X = (k == 0) ? vga_pkg::LIVES1_X : vga_pkg::LIVES2_X;
		for (genvar j = 0; j < N_MARKERS; j++) begin : g_marker
			// Marker j only drawn while its lives bit is set
			assign mark_cover[k][j] = lives[k][j] &&
				in_span(pix_in.x, vga_pkg::coord_t'(BASE_X + j * vga_pkg::MARKER_PITCH),
					vga_pkg::MARKER_SIZE) &&
				in_span(pix_in.y, vga_pkg::coord_t'(vga_pkg::MARKER_Y), vga_pkg::MARKER_SIZE);
		end
		assign marker_next[k] = |mark_cover[k];
	end

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			pix_out.x <= '0;
			pix_out.y <= '0;
			pix_out.active <= 1'b0;
			pix_out.hs <= 1'b1;
			pix_out.vs <= 1'b1;
			p1_hit <= 1'b0;
			p2_hit <= 1'b0;
			marker_hit <= '0;
		end else begin
			pix_out.x <= pix_in.x;
			pix_out.y <= pix_in.y;
			pix_out.active <= pix_in.active;
			pix_out.hs <= pix_in.hs;
			pix_out.vs <= pix_in.vs;
			p1_hit <= p1_next;
			p2_hit <= p2_next;
			marker_hit <= marker_next;
		end
	end

endmodule

/* src/color_compose_stage.sv */
`timescale 1ns/1ps

module color_compose_stage (
	input logic VGA_CLK_n,
	input logic iRST_n,
	pixel_if.snk pix,
	input logic p1_hit,
	input logic p2_hit,
	input logic [1:0] marker_hit,
	input vga_pkg::lives_t p1_lives,
	input vga_pkg::lives_t p2_lives,
	output logic hs,
	output logic vs,
	output logic blank_n,
	output logic [7:0] r,
	output logic [7:0] g,
	output logic [7:0] b
);

	vga_pkg::rgb_t color_next;
	vga_pkg::rgb_t color_q;

	// Front to back, markers stay on top of the end screen
	always_comb begin
		if (!pix.active)
			color_next = '0;
		else if (marker_hit[1])
			color_next = vga_pkg::COLOR_LIVES2;
		else if (marker_hit[0])
			color_next = vga_pkg::COLOR_LIVES1;
		else if (p1_lives == '0)
			color_next = vga_pkg::COLOR_END1;
		else if (p2_lives == '0)
			color_next = vga_pkg::COLOR_END2;
		else if (p2_hit)
			color_next = vga_pkg::COLOR_P2;
		else if (p1_hit)
			color_next = vga_pkg::COLOR_P1;
		else
			color_next = vga_pkg::COLOR_BG;
	end

	always_ff @(posedge VGA_CLK_n or negedge iRST_n) begin
		if (!iRST_n) begin
			hs <= 1'b1;
			vs <= 1'b1;
			blank_n <= 1'b0;
			color_q <= '0;
		end else begin
			hs <= pix.hs;
			vs <= pix.vs;
			blank_n <= pix.active;
			color_q <= color_next;
		end
	end

	assign b = color_q[23:16];
	assign g = color_q[15:8];
	assign r = color_q[7:0];

endmodule

/* src/vga_overlay_top.sv */
`timescale 1ns/1ps

module vga_overlay_top (
	input logic VGA_CLK_n,
	input logic iRST_n,
	input vga_pkg::coord_t p1_x,
	input vga_pkg::coord_t p1_y,
	input vga_pkg::coord_t p2_x,
	input vga_pkg::coord_t p2_y,
	input vga_pkg::lives_t p1_lives,
	input vga_pkg::lives_t p2_lives,
	output logic hs,
	output logic vs,
	output logic blank_n,
	output logic [7:0] r,
	output logic [7:0] g,
	output logic [7:0] b
);

	// Counter stage to hit stage, then hit stage to colour stage
	pixel_if pix0 ();
	pixel_if pix1 ();

	logic p1_hit;
	logic p2_hit;
	logic [1:0] marker_hit;

	vga_sync_gen sync_i (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n (iRST_n),
		.pix (pix0.src)
	);

	sprite_hit_stage hit_i (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n (iRST_n),
		.pix_in (pix0.snk),
		.pix_out (pix1.src),
		.p1_x (p1_x),
		.p1_y (p1_y),
		.p2_x (p2_x),
		.p2_y (p2_y),
		.p1_lives (p1_lives),
		.p2_lives (p2_lives),
		.p1_hit (p1_hit),
		.p2_hit (p2_hit),
		.marker_hit (marker_hit)
	);

	color_compose_stage compose_i (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n (iRST_n),
		.pix (pix1.snk),
		.p1_hit (p1_hit),
		.p2_hit (p2_hit),
		.marker_hit (marker_hit),
		.p1_lives (p1_lives),
		.p2_lives (p2_lives),
		.hs (hs),
		.vs (vs),
		.blank_n (blank_n),
		.r (r),
		.g (g),
		.b (b)
	);

endmodule

/* tests/vga_checker.sv */
`timescale 1ns/1ps

module vga_checker (
	input logic VGA_CLK_n,
	input logic iRST_n,
	input logic hs,
	input logic vs,
	input logic blank_n,
	input logic [7:0] r,
	input logic [7:0] g,
	input logic [7:0] b,
	input vga_pkg::coord_t p1_x,
	input vga_pkg::coord_t p1_y,
	input vga_pkg::coord_t p2_x,
	input vga_pkg::coord_t p2_y,
	input vga_pkg::lives_t p1_lives,
	input vga_pkg::lives_t p2_lives,
	output int errors,
	output int pixels_checked
);

	int err_count = 0;
	int pix_count = 0;
	int h_pos = 0;
	int v_pos = 0;
	int since_h = 0;
	int since_v = 0;
	int low_h = 0;
	int low_v = 0;
	bit h_known = 0;
	bit v_known = 0;
	bit h_fell = 0;
	bit v_fell = 0;
	bit exp_active;
	logic [23:0] exp_rgb;
	logic prev_hs = 1'b1;
	logic prev_vs = 1'b1;

	assign errors = err_count;
	assign pixels_checked = pix_count;

	task automatic log_error(input string msg);
		err_count++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	function automatic bit covers(input int pos, input int lo, input int size);
		return (pos >= lo) && (pos < lo + size);
	endfunction

	function automatic bit marker_at(input int x, input int y, input int base,
		input vga_pkg::lives_t mask);
		bit hit;
		hit = 0;
		for (int j = 0; j < 5; j++)
			if (mask[j] && covers(x, base + j * vga_pkg::MARKER_PITCH, vga_pkg::MARKER_SIZE) &&
				covers(y, vga_pkg::MARKER_Y, vga_pkg::MARKER_SIZE))
				hit = 1;
		return hit;
	endfunction

	// Front layer first
	function automatic logic [23:0] expected_color(input int x, input int y);
		if (marker_at(x, y, vga_pkg::LIVES2_X, p2_lives))
			return vga_pkg::COLOR_LIVES2;
		if (marker_at(x, y, vga_pkg::LIVES1_X, p1_lives))
			return vga_pkg::COLOR_LIVES1;
		if (p1_lives == '0)
			return vga_pkg::COLOR_END1;
		if (p2_lives == '0)
			return vga_pkg::COLOR_END2;
		if (covers(x, p2_x, vga_pkg::SPRITE_SIZE) && covers(y, p2_y, vga_pkg::SPRITE_SIZE))
			return vga_pkg::COLOR_P2;
		if (covers(x, p1_x, vga_pkg::SPRITE_SIZE) && covers(y, p1_y, vga_pkg::SPRITE_SIZE))
			return vga_pkg::COLOR_P1;
		return vga_pkg::COLOR_BG;
	endfunction

	always @(negedge VGA_CLK_n) begin
		if (!iRST_n) begin
			if (!hs || !vs || blank_n || {b, g, r} != 24'h0)
				log_error("outputs not idle during reset");
			h_known = 0;
			v_known = 0;
			h_fell = 0;
			v_fell = 0;
		end else begin
			since_h++;
			since_v++;
			if (h_known) begin
				h_pos = (h_pos == 799) ? 0 : h_pos + 1;
				if (h_pos == 0 && v_known)
					v_pos = (v_pos == 524) ? 0 : v_pos + 1;
			end
			// Sync fall marks x = 656 and y = 490
			if (prev_hs && !hs) begin
				if (h_fell && since_h != 800)
					log_error($sformatf("hs period %0d, expected 800", since_h));
				h_fell = 1;
				since_h = 0;
				low_h = 0;
				h_pos = 656;
				h_known = 1;
			end
			if (!hs)
				low_h++;
			if (!prev_hs && hs && h_fell && low_h != 96)
				log_error($sformatf("hs low for %0d cycles, expected 96", low_h));
			if (prev_vs && !vs) begin
				if (v_fell && since_v != 800 * 525)
					log_error($sformatf("vs period %0d cycles, expected 420000", since_v));
				if (h_known && h_pos != 0)
					log_error($sformatf("vs fell at x %0d, expected 0", h_pos));
				v_fell = 1;
				since_v = 0;
				low_v = 0;
				v_pos = 490;
				v_known = 1;
			end
			if (!vs)
				low_v++;
			if (!prev_vs && vs && v_fell && low_v != 2 * 800)
				log_error($sformatf("vs low for %0d cycles, expected 1600", low_v));
			if (h_known && v_known) begin
				exp_active = (h_pos < 640) && (v_pos < 480);
				if (blank_n != exp_active) begin
					log_error($sformatf("blank_n %b at (%0d,%0d)", blank_n, h_pos, v_pos));
				end else if (exp_active) begin
					pix_count++;
					exp_rgb = expected_color(h_pos, v_pos);
					if ({b, g, r} != exp_rgb)
						log_error($sformatf("pixel (%0d,%0d) is %h, expected %h",
							h_pos, v_pos, {b, g, r}, exp_rgb));
				end
			end
			if (!blank_n && {b, g, r} != 24'h0)
				log_error($sformatf("colour %h while blanked", {b, g, r}));
		end
		prev_hs = hs;
		prev_vs = vs;
	end

endmodule

/* tests/tb_vga_overlay.sv */
`timescale 1ns/1ps

module tb_vga_overlay;

	localparam int VSYNC_TIMEOUT = 2 * 800 * 525;
	localparam int N_FRAMES = 6;

	logic VGA_CLK_n;
	logic iRST_n;
	vga_pkg::coord_t p1_x;
	vga_pkg::coord_t p1_y;
	vga_pkg::coord_t p2_x;
	vga_pkg::coord_t p2_y;
	vga_pkg::lives_t p1_lives;
	vga_pkg::lives_t p2_lives;
	logic hs;
	logic vs;
	logic blank_n;
	logic [7:0] r;
	logic [7:0] g;
	logic [7:0] b;
	int errors;
	int pixels_checked;
	int timeouts;
	logic [31:0] lcg_state;
	bit found;

	always #20 VGA_CLK_n = ~VGA_CLK_n;

	vga_overlay_top dut_i (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n (iRST_n),
		.p1_x (p1_x),
		.p1_y (p1_y),
		.p2_x (p2_x),
		.p2_y (p2_y),
		.p1_lives (p1_lives),
		.p2_lives (p2_lives),
		.hs (hs),
		.vs (vs),
		.blank_n (blank_n),
		.r (r),
		.g (g),
		.b (b)
	);

	vga_checker check_i (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n (iRST_n),
		.hs (hs),
		.vs (vs),
		.blank_n (blank_n),
		.r (r),
		.g (g),
		.b (b),
		.p1_x (p1_x),
		.p1_y (p1_y),
		.p2_x (p2_x),
		.p2_y (p2_y),
		.p1_lives (p1_lives),
		.p2_lives (p2_lives),
		.errors (errors),
		.pixels_checked (pixels_checked)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic rand_below(input int n, output int v);
		lcg_state = lcg_step(lcg_state);
		v = int'(lcg_state[30:16]) % n;
	endtask

	task automatic wait_vsync(output bit ok);
		int cycles;
		logic last_vs;
		cycles = 0;
		ok = 0;
		last_vs = vs;
		while (!ok && cycles < VSYNC_TIMEOUT) begin
			@(negedge VGA_CLK_n);
			cycles++;
			if (last_vs && !vs)
				ok = 1;
			last_vs = vs;
		end
	endtask

	task automatic pick_set(input int frame);
		int v [6];
		for (int i = 0; i < 6; i++)
			rand_below(640, v[i]);
		p1_x = vga_pkg::coord_t'(v[0]);
		p1_y = vga_pkg::coord_t'(v[1] % 480);
		p2_x = vga_pkg::coord_t'(v[2]);
		p2_y = vga_pkg::coord_t'(v[3] % 480);
		p1_lives = vga_pkg::lives_t'(v[4]);
		p2_lives = vga_pkg::lives_t'(v[5]);
		case (frame)
			1: p1_lives = '0;
			2: begin
				// Player 2 box overlaps player 1
				p1_x = vga_pkg::coord_t'(v[0] % 600);
				p1_y = vga_pkg::coord_t'(v[1] % 440);
				p2_x = p1_x + vga_pkg::coord_t'(v[2] % 32);
				p2_y = p1_y + vga_pkg::coord_t'(v[3] % 32);
			end
			3: p2_lives = '0;
			4: begin
				// Boxes slide under the marker rows
				p1_x = vga_pkg::coord_t'(vga_pkg::LIVES1_X - 10 + v[0] % 40);
				p1_y = vga_pkg::coord_t'(v[1] % 16);
				p2_x = vga_pkg::coord_t'(vga_pkg::LIVES2_X - 10 + v[2] % 40);
				p2_y = vga_pkg::coord_t'(v[3] % 16);
			end
			default: ;
		endcase
		if (frame != 1 && p1_lives == '0)
			p1_lives = 5'b10110;
		if (frame != 3 && p2_lives == '0)
			p2_lives = 5'b01101;
	endtask

	initial begin
		VGA_CLK_n = 1'b0;
		iRST_n = 1'b0;
		p1_x = 10'd100;
		p1_y = 10'd200;
		p2_x = 10'd400;
		p2_y = 10'd220;
		p1_lives = 5'b11111;
		p2_lives = 5'b11111;
		lcg_state = 32'h9415;
		timeouts = 0;
		repeat (3) @(posedge VGA_CLK_n);
		#2 iRST_n = 1'b1;
		// One extra vsync lets the last set reach the screen
		for (int frame = 0; frame <= N_FRAMES && timeouts == 0; frame++) begin
			wait_vsync(found);
			if (!found) begin
				$display("Timeout: vs did not fall within %0d cycles", VSYNC_TIMEOUT);
				timeouts++;
			end else if (frame < N_FRAMES) begin
				@(posedge VGA_CLK_n);
				#2;
				pick_set(frame);
			end
		end
		if (pixels_checked == 0)
			$display("No active pixels were checked");
		$display("Pixels checked: %0d, errors: %0d, timeouts: %0d",
			pixels_checked, errors, timeouts);
		if (errors == 0 && timeouts == 0 && pixels_checked > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* vga_overlay.f */
src/vga_pkg.sv
src/pixel_if.sv
src/vga_sync_gen.sv
src/sprite_hit_stage.sv
src/color_compose_stage.sv
src/vga_overlay_top.sv
tests/vga_checker.sv
tests/tb_vga_overlay.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module tb_vga_overlay \
	-f vga_overlay.f \
	-o tb_vga_overlay

out=$(./obj_dir/tb_vga_overlay)
echo "$out"
echo "$out" | grep -q "All tests passed"
